/* project.f */
mem_pkg.sv
mem_compact.sv
mem_dispatch_steer.sv
mem_issue_queue.sv
mem_issue_stage.sv
mem_block.sv
tb_mem_block.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_block
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_mem_block.sv */
// Directed testbench for the memory dispatch and issue block.
// Sources are ready at dispatch except in the wakeup and squash tests, so every queue drains.
`timescale 1ns/1ps
`default_nettype none

module tb_mem_block
    import mem_pkg::*;
();

    localparam int DISP_WIDTH      = 4;
    localparam int LQ_DEPTH        = 8;
    localparam int SQ_DEPTH        = 8;
    localparam int WB_PORTS        = 4;
    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 10;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 200;
    localparam int WATCHDOG_NS     = (RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) * CLK_PERIOD;
    localparam int DRAIN_LIMIT     = 64;

    // one expected issue with the sources it still waits for
    typedef struct packed {
        mem_uop_t uop;
        src_rdy_t pend;
    } exp_ent_t;

    logic                  clk;
    logic                  rst_n;
    logic                  squash;
    logic [DISP_WIDTH-1:0] disp_req;
    mem_uop_t              disp_uop [DISP_WIDTH];
    src_rdy_t              disp_rdy [DISP_WIDTH];
    logic [DISP_WIDTH-1:0] disp_ack;
    logic [WB_PORTS-1:0]   wb_vld;
    logic [PREG_W-1:0]     wb_tag [WB_PORTS];
    logic                  ld_stall;
    logic                  st_stall;
    logic                  ld_vld;
    mem_issue_t            ld_issue;
    logic                  st_vld;
    mem_issue_t            st_issue;

    // stimulus for the coming cycle
    logic [DISP_WIDTH-1:0] nxt_req;
    mem_uop_t              nxt_uop [DISP_WIDTH];
    src_rdy_t              nxt_rdy [DISP_WIDTH];
    logic [WB_PORTS-1:0]   nxt_wb_vld;
    logic [PREG_W-1:0]     nxt_wb_tag [WB_PORTS];
    logic                  nxt_squash;
    logic                  nxt_ld_stall;
    logic                  nxt_st_stall;

    // reference model state
    exp_ent_t              exp_q [$];
    exp_ent_t              acc_q [$];
    logic                  squash_q;
    logic                  ld_stall_q;
    logic                  st_stall_q;
    logic [31:0]           lfsr;

    mem_block #(
        .DISP_WIDTH (DISP_WIDTH),
        .LQ_DEPTH   (LQ_DEPTH),
        .SQ_DEPTH   (SQ_DEPTH),
        .WB_PORTS   (WB_PORTS)
    ) u_dut (
        .clk        (clk),
        .i_rst_n    (rst_n),
        .i_squash   (squash),
        .i_disp_req (disp_req),
        .i_disp_uop (disp_uop),
        .i_disp_rdy (disp_rdy),
        .o_disp_ack (disp_ack),
        .i_wb_vld   (wb_vld),
        .i_wb_tag   (wb_tag),
        .i_ld_stall (ld_stall),
        .i_st_stall (st_stall),
        .o_ld_vld   (ld_vld),
        .o_ld_issue (ld_issue),
        .o_st_vld   (st_vld),
        .o_st_issue (st_issue)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic fail_now(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        stop_run();
    endtask

    task automatic check_ack(input string name, input logic [DISP_WIDTH-1:0] got,
                             input logic [DISP_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_issue(input string name, input mem_issue_t got, input mem_issue_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_vld(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    // fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic        fb;
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic make_uop(input mem_kind_e kind, output mem_uop_t u);
        logic [31:0] r;
        u.kind = kind;
        r = take_bits(ROB_W);
        u.rob_idx = r[ROB_W-1:0];
        for (int s = 0; s < NUM_SRCS; s++) begin
            r = take_bits(PREG_W);
            u.src_tag[s] = r[PREG_W-1:0];
        end
        r = take_bits(PREG_W);
        u.dst_tag = r[PREG_W-1:0];
        r = take_bits(IMM_W);
        u.imm = r[IMM_W-1:0];
    endtask

    function automatic logic tag_woken(input logic [PREG_W-1:0] tag);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < WB_PORTS; w++) begin
            if (nxt_wb_vld[w] && (nxt_wb_tag[w] == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic int count_kind(input mem_kind_e kind);
        int n;
        n = 0;
        foreach (exp_q[i]) begin
            if (exp_q[i].uop.kind == kind) begin
                n++;
            end
        end
        return n;
    endfunction

    // in-order prefix with at most two per queue and two free entries needed
    function automatic logic [DISP_WIDTH-1:0] predict_ack(input int lq_free, input int sq_free);
        logic [DISP_WIDTH-1:0] ack;
        int                    n_ld;
        int                    n_st;
        logic                  stop;
        ack  = '0;
        n_ld = 0;
        n_st = 0;
        stop = 1'b0;
        for (int i = 0; i < DISP_WIDTH; i++) begin
            if (!stop && nxt_req[i]) begin
                if (nxt_uop[i].kind == MEM_LOAD) begin
                    if (lq_free >= 2 && n_ld < 2) begin
                        ack[i] = 1'b1;
                        n_ld++;
                    end
                end else if (sq_free >= 2 && n_st < 2) begin
                    ack[i] = 1'b1;
                    n_st++;
                end
            end
            stop = stop || !ack[i];
        end
        return ack;
    endfunction

    // an issued micro-op must be pending, woken and on its own port
    task automatic take_issue(input string port, input mem_kind_e kind, input mem_issue_t got);
        int         idx;
        mem_issue_t exp_iss;
        idx = -1;
        foreach (exp_q[i]) begin
            if (idx < 0 && exp_q[i].uop == got.uop) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            fail_now($sformatf("%s issued rob %0d which is not pending", port, got.uop.rob_idx));
        end else begin
            if (exp_q[idx].uop.kind != kind) begin
                fail_now($sformatf("%s issued a micro-op of the other queue", port));
            end
            if (exp_q[idx].pend != '0) begin
                fail_now($sformatf("%s issued rob %0d before its sources were woken",
                                   port, got.uop.rob_idx));
            end
            exp_iss.uop = exp_q[idx].uop;
            for (int s = 0; s < NUM_SRCS; s++) begin
                exp_iss.rf_idx[s] = exp_q[idx].uop.src_tag[s];
            end
            check_issue(port, got, exp_iss);
            exp_q.delete(idx);
        end
    endtask

    // drive on the rising edge and check against the model at the falling edge
    task automatic step_cycle();
        logic [DISP_WIDTH-1:0] exp_ack;
        exp_ent_t              e;
        @(posedge clk);
        disp_req <= nxt_req;
        for (int i = 0; i < DISP_WIDTH; i++) begin
            disp_uop[i] <= nxt_uop[i];
            disp_rdy[i] <= nxt_rdy[i];
        end
        wb_vld <= nxt_wb_vld;
        for (int w = 0; w < WB_PORTS; w++) begin
            wb_tag[w] <= nxt_wb_tag[w];
        end
        squash   <= nxt_squash;
        ld_stall <= nxt_ld_stall;
        st_stall <= nxt_st_stall;
        @(negedge clk);
        if (squash_q) begin
            exp_q.delete();
            acc_q.delete();
        end
        while (acc_q.size() > 0) begin
            exp_q.push_back(acc_q.pop_front());
        end
        // a held stage shows nothing new
        if (ld_vld && !ld_stall_q) begin
            take_issue("o_ld_issue", MEM_LOAD, ld_issue);
        end
        if (st_vld && !st_stall_q) begin
            take_issue("o_st_issue", MEM_STORE, st_issue);
        end
        foreach (exp_q[i]) begin
            e = exp_q[i];
            for (int s = 0; s < NUM_SRCS; s++) begin
                if (tag_woken(e.uop.src_tag[s])) begin
                    e.pend[s] = 1'b0;
                end
            end
            exp_q[i] = e;
        end
        exp_ack = predict_ack(LQ_DEPTH - count_kind(MEM_LOAD), SQ_DEPTH - count_kind(MEM_STORE));
        check_ack("o_disp_ack", disp_ack, exp_ack);
        if (!nxt_squash) begin
            for (int i = 0; i < DISP_WIDTH; i++) begin
                if (exp_ack[i]) begin
                    e.uop = nxt_uop[i];
                    for (int s = 0; s < NUM_SRCS; s++) begin
                        e.pend[s] = !nxt_rdy[i][s] && !tag_woken(nxt_uop[i].src_tag[s]);
                    end
                    acc_q.push_back(e);
                end
            end
        end
        squash_q   = nxt_squash;
        ld_stall_q = nxt_ld_stall;
        st_stall_q = nxt_st_stall;
        // requests, broadcasts and squash last a single cycle
        nxt_req    = '0;
        nxt_wb_vld = '0;
        nxt_squash = 1'b0;
    endtask

    task automatic set_slot(input int i, input mem_kind_e kind, input src_rdy_t rdy);
        mem_uop_t u;
        make_uop(kind, u);
        nxt_uop[i] = u;
        nxt_rdy[i] = rdy;
        nxt_req[i] = 1'b1;
    endtask

    task automatic dispatch_pattern(input logic [DISP_WIDTH-1:0] req,
                                    input logic [DISP_WIDTH-1:0] st, input src_rdy_t rdy);
        for (int i = 0; i < DISP_WIDTH; i++) begin
            if (st[i]) begin
                set_slot(i, MEM_STORE, rdy);
            end else begin
                set_slot(i, MEM_LOAD, rdy);
            end
        end
        // gap slots still carry a micro-op
        nxt_req = req;
        step_cycle();
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() > 0 || acc_q.size() > 0) begin
            if (n >= DRAIN_LIMIT) begin
                fail_now("queues did not drain in time");
            end
            step_cycle();
            n++;
        end
    endtask

    task automatic test_steer_prefix();
        logic [31:0] r_req;
        logic [31:0] r_st;
        // slot order L L L S with the third load over the limit
        dispatch_pattern(4'b1111, 4'b1000, 2'b11);
        dispatch_pattern(4'b1111, 4'b0101, 2'b11);
        // gap in slot 2 stops the prefix
        dispatch_pattern(4'b1011, 4'b0000, 2'b11);
        dispatch_pattern(4'b1111, 4'b0111, 2'b11);
        dispatch_pattern(4'b1110, 4'b0000, 2'b11);
        dispatch_pattern(4'b1111, 4'b1010, 2'b11);
        repeat (12) begin
            r_req = take_bits(DISP_WIDTH);
            r_st  = take_bits(DISP_WIDTH);
            dispatch_pattern(r_req[DISP_WIDTH-1:0], r_st[DISP_WIDTH-1:0], 2'b11);
        end
        wait_drain();
    endtask

    task automatic test_ready_issue();
        for (int k = 0; k < 4; k++) begin
            dispatch_pattern(4'b0011, (k % 2 == 0) ? 4'b0010 : 4'b0001, 2'b11);
            step_cycle();
            check_vld("o_ld_vld", ld_vld, 1'b0);
            check_vld("o_st_vld", st_vld, 1'b0);
            // second edge after acceptance
            step_cycle();
            check_vld("o_ld_vld", ld_vld, 1'b1);
            check_vld("o_st_vld", st_vld, 1'b1);
        end
        wait_drain();
    endtask

    task automatic test_wakeup();
        logic [PREG_W-1:0] tags [$];
        set_slot(0, MEM_LOAD, 2'b00);
        set_slot(1, MEM_STORE, 2'b00);
        set_slot(2, MEM_LOAD, 2'b01);
        set_slot(3, MEM_STORE, 2'b10);
        step_cycle();
        repeat (4) begin
            step_cycle();
            check_vld("o_ld_vld", ld_vld, 1'b0);
            check_vld("o_st_vld", st_vld, 1'b0);
        end
        // broadcast in the enqueue cycle
        set_slot(0, MEM_LOAD, 2'b00);
        nxt_wb_vld    = 4'b0011;
        nxt_wb_tag[0] = nxt_uop[0].src_tag[0];
        nxt_wb_tag[1] = nxt_uop[0].src_tag[1];
        step_cycle();
        foreach (exp_q[i]) begin
            for (int s = 0; s < NUM_SRCS; s++) begin
                if (exp_q[i].pend[s]) begin
                    tags.push_back(exp_q[i].uop.src_tag[s]);
                end
            end
        end
        while (tags.size() > 0) begin
            for (int w = 0; w < WB_PORTS; w++) begin
                if (tags.size() > 0) begin
                    nxt_wb_vld[w] = 1'b1;
                    nxt_wb_tag[w] = tags.pop_front();
                end
            end
            step_cycle();
        end
        wait_drain();
    endtask

    task automatic test_full_backpressure();
        mem_issue_t held;
        dispatch_pattern(4'b0001, 4'b0000, 2'b11);
        // the only load dispatched is the one the stage will hold
        held.uop = nxt_uop[0];
        for (int s = 0; s < NUM_SRCS; s++) begin
            held.rf_idx[s] = nxt_uop[0].src_tag[s];
        end
        step_cycle();
        nxt_ld_stall = 1'b1;
        step_cycle();
        check_vld("o_ld_vld", ld_vld, 1'b1);
        check_issue("o_ld_issue", ld_issue, held);
        // store first so it keeps its ack once loads are refused
        repeat (6) begin
            dispatch_pattern(4'b0111, 4'b0001, 2'b11);
            check_vld("o_ld_vld", ld_vld, 1'b1);
            check_issue("o_ld_issue", ld_issue, held);
        end
        check_ack("o_disp_ack", disp_ack, 4'b0001);
        if (count_kind(MEM_LOAD) != LQ_DEPTH) begin
            fail_now("load queue did not fill while the load stage was stalled");
        end
        nxt_ld_stall = 1'b0;
        wait_drain();
    endtask

    task automatic test_squash();
        logic [PREG_W-1:0] old_tags [WB_PORTS];
        set_slot(0, MEM_LOAD, 2'b11);
        set_slot(1, MEM_STORE, 2'b11);
        set_slot(2, MEM_LOAD, 2'b00);
        set_slot(3, MEM_STORE, 2'b00);
        old_tags[0] = nxt_uop[2].src_tag[0];
        old_tags[1] = nxt_uop[2].src_tag[1];
        old_tags[2] = nxt_uop[3].src_tag[0];
        old_tags[3] = nxt_uop[3].src_tag[1];
        step_cycle();
        step_cycle();
        nxt_squash = 1'b1;
        set_slot(0, MEM_LOAD, 2'b11);
        step_cycle();
        check_vld("o_ld_vld", ld_vld, 1'b1);
        check_vld("o_st_vld", st_vld, 1'b1);
        step_cycle();
        check_vld("o_ld_vld", ld_vld, 1'b0);
        check_vld("o_st_vld", st_vld, 1'b0);
        // waking the flushed sources must not bring them back
        for (int w = 0; w < WB_PORTS; w++) begin
            nxt_wb_vld[w] = 1'b1;
            nxt_wb_tag[w] = old_tags[w];
        end
        step_cycle();
        repeat (3) begin
            step_cycle();
            check_vld("o_ld_vld", ld_vld, 1'b0);
            check_vld("o_st_vld", st_vld, 1'b0);
        end
        dispatch_pattern(4'b1111, 4'b0101, 2'b11);
        check_ack("o_disp_ack", disp_ack, 4'b1111);
        wait_drain();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR at %0t ns: watchdog expired before the tests finished", $time);
        stop_run();
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        squash       = 1'b0;
        disp_req     = '0;
        wb_vld       = '0;
        ld_stall     = 1'b0;
        st_stall     = 1'b0;
        nxt_req      = '0;
        nxt_wb_vld   = '0;
        nxt_squash   = 1'b0;
        nxt_ld_stall = 1'b0;
        nxt_st_stall = 1'b0;
        for (int i = 0; i < DISP_WIDTH; i++) begin
            disp_uop[i] = '0;
            disp_rdy[i] = '0;
            nxt_uop[i]  = '0;
            nxt_rdy[i]  = '0;
        end
        for (int w = 0; w < WB_PORTS; w++) begin
            wb_tag[w]     = '0;
            nxt_wb_tag[w] = '0;
        end
        squash_q   = 1'b0;
        ld_stall_q = 1'b0;
        st_stall_q = 1'b0;
        lfsr       = 32'h432b3e16;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_vld("o_ld_vld", ld_vld, 1'b0);
        check_vld("o_st_vld", st_vld, 1'b0);
        test_steer_prefix();
        test_ready_issue();
        test_wakeup();
        test_full_backpressure();
        test_squash();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* mem_block.sv */
// Memory dispatch and issue block: steering, load and store queues, issue stages.
// Loads go only to the load queue and stores only to the store queue.
`timescale 1ns/1ps
`default_nettype none

module mem_block
    import mem_pkg::*;
#(
    parameter int DISP_WIDTH = 4,
    parameter int LQ_DEPTH   = 8,
    parameter int SQ_DEPTH   = 8,
    parameter int WB_PORTS   = 4
) (
    input  wire logic                  clk,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_squash,

    input  wire logic [DISP_WIDTH-1:0] i_disp_req,
    input  mem_uop_t                   i_disp_uop [DISP_WIDTH],
    input  src_rdy_t                   i_disp_rdy [DISP_WIDTH],
    output logic [DISP_WIDTH-1:0]      o_disp_ack,

    input  wire logic [WB_PORTS-1:0]   i_wb_vld,
    input  wire logic [PREG_W-1:0]     i_wb_tag [WB_PORTS],

    input  wire logic                  i_ld_stall,
    input  wire logic                  i_st_stall,

    output logic                       o_ld_vld,
    output mem_issue_t                 o_ld_issue,
    output logic                       o_st_vld,
    output mem_issue_t                 o_st_issue
);

    logic                 lq_can_enq;
    logic                 sq_can_enq;
    logic [ENQ_PORTS-1:0] lq_enq_vld;
    mem_uop_t             lq_enq_uop [ENQ_PORTS];
    src_rdy_t             lq_enq_rdy [ENQ_PORTS];
    logic [ENQ_PORTS-1:0] sq_enq_vld;
    mem_uop_t             sq_enq_uop [ENQ_PORTS];
    src_rdy_t             sq_enq_rdy [ENQ_PORTS];

    logic                 ld_iss_vld;
    mem_uop_t             ld_iss_uop;
    logic                 st_iss_vld;
    mem_uop_t             st_iss_uop;

    mem_dispatch_steer #(.DISP_WIDTH(DISP_WIDTH)) u_steer (
        .i_disp_req   (i_disp_req),
        .i_disp_uop   (i_disp_uop),
        .i_disp_rdy   (i_disp_rdy),
        .i_lq_can_enq (lq_can_enq),
        .i_sq_can_enq (sq_can_enq),
        .o_disp_ack   (o_disp_ack),
        .o_lq_enq_vld (lq_enq_vld),
        .o_lq_enq_uop (lq_enq_uop),
        .o_lq_enq_rdy (lq_enq_rdy),
        .o_sq_enq_vld (sq_enq_vld),
        .o_sq_enq_uop (sq_enq_uop),
        .o_sq_enq_rdy (sq_enq_rdy)
    );

    mem_issue_queue #(.DEPTH(LQ_DEPTH), .WB_PORTS(WB_PORTS)) u_lq (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_squash  (i_squash),
        .i_enq_vld (lq_enq_vld),
        .i_enq_uop (lq_enq_uop),
        .i_enq_rdy (lq_enq_rdy),
        .i_wb_vld  (i_wb_vld),
        .i_wb_tag  (i_wb_tag),
        .i_stall   (i_ld_stall),
        .o_can_enq (lq_can_enq),
        .o_iss_vld (ld_iss_vld),
        .o_iss_uop (ld_iss_uop)
    );

    mem_issue_queue #(.DEPTH(SQ_DEPTH), .WB_PORTS(WB_PORTS)) u_sq (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_squash  (i_squash),
        .i_enq_vld (sq_enq_vld),
        .i_enq_uop (sq_enq_uop),
        .i_enq_rdy (sq_enq_rdy),
        .i_wb_vld  (i_wb_vld),
        .i_wb_tag  (i_wb_tag),
        .i_stall   (i_st_stall),
        .o_can_enq (sq_can_enq),
        .o_iss_vld (st_iss_vld),
        .o_iss_uop (st_iss_uop)
    );

    // queue and stage share the stall so a held stage never loses an issue
    mem_issue_stage u_ld_stage (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_squash (i_squash),
        .i_stall  (i_ld_stall),
        .i_vld    (ld_iss_vld),
        .i_uop    (ld_iss_uop),
        .o_vld    (o_ld_vld),
        .o_issue  (o_ld_issue)
    );

    mem_issue_stage u_st_stage (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_squash (i_squash),
        .i_stall  (i_st_stall),
        .i_vld    (st_iss_vld),
        .i_uop    (st_iss_uop),
        .o_vld    (o_st_vld),
        .o_issue  (o_st_issue)
    );

endmodule

`default_nettype wire

/* mem_issue_stage.sv */
// Registered issue stage between a queue and its execution port.
// Holds its contents while i_stall is high; squash drops the valid at the next edge.
`timescale 1ns/1ps
`default_nettype none

module mem_issue_stage
    import mem_pkg::*;
(
    input  wire logic clk,
    input  wire logic i_rst_n,
    input  wire logic i_squash,
    input  wire logic i_stall,
    input  wire logic i_vld,
    input  mem_uop_t  i_uop,

    output logic       o_vld,
    output mem_issue_t o_issue
);

    mem_issue_t iss_nxt;

    // register file read indices are the source tags
    always_comb begin
        iss_nxt.uop = i_uop;
        for (int s = 0; s < NUM_SRCS; s++) begin
            iss_nxt.rf_idx[s] = i_uop.src_tag[s];
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_vld <= 1'b0;
        end else if (i_squash) begin
            o_vld <= 1'b0;
        end else if (!i_stall) begin
            o_vld <= i_vld;
        end
    end

    // payload only moves when a new micro-op arrives
    always_ff @(posedge clk) begin
        if (!i_stall && i_vld) begin
            o_issue <= iss_nxt;
        end
    end

endmodule

`default_nettype wire

/* mem_issue_queue.sv */
// Issue queue holding micro-ops until both sources are ready, one issue per cycle.
// Enqueue ports must be packed from port 0; o_can_enq means ENQ_PORTS entries are free.
// Wakeup sets a ready bit at the edge, so a woken entry is selectable one cycle later.
`timescale 1ns/1ps
`default_nettype none

module mem_issue_queue
    import mem_pkg::*;
#(
    parameter int DEPTH    = 8,
    parameter int WB_PORTS = 4
) (
    input  wire logic                 clk,
    input  wire logic                 i_rst_n,
    input  wire logic                 i_squash,

    input  wire logic [ENQ_PORTS-1:0] i_enq_vld,
    input  mem_uop_t                  i_enq_uop [ENQ_PORTS],
    input  src_rdy_t                  i_enq_rdy [ENQ_PORTS],

    input  wire logic [WB_PORTS-1:0]  i_wb_vld,
    input  wire logic [PREG_W-1:0]    i_wb_tag [WB_PORTS],

    input  wire logic                 i_stall,

    output logic                      o_can_enq,
    output logic                      o_iss_vld,
    output mem_uop_t                  o_iss_uop
);

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DEPTH-1:0] ent_vld;
    mem_uop_t         ent_uop [DEPTH];
    src_rdy_t         ent_rdy [DEPTH];
    logic [CNT_W-1:0] free_cnt;
    logic [CNT_W-1:0] free_nxt;

    logic [IDX_W-1:0] free_idx [ENQ_PORTS];
    logic [CNT_W-1:0] enq_cnt;
    src_rdy_t         enq_rdy_w [ENQ_PORTS];

    logic             sel_found;
    logic [IDX_W-1:0] sel_idx;
    logic             iss_fire;

    // tag match against any valid writeback port
    function automatic logic wb_hit(input logic [PREG_W-1:0] tag);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < WB_PORTS; w++) begin
            if (i_wb_vld[w] && (i_wb_tag[w] == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // lowest free entries, one per enqueue port
    always_comb begin : free_blk
        int nfree;
        nfree = 0;
        for (int p = 0; p < ENQ_PORTS; p++) begin
            free_idx[p] = '0;
        end
        for (int e = 0; e < DEPTH; e++) begin
            if (!ent_vld[e]) begin
                if (nfree < ENQ_PORTS) begin
                    free_idx[nfree] = IDX_W'(e);
                end
                nfree = nfree + 1;
            end
        end
    end

    // ready bits at enqueue, including a same-cycle broadcast
    always_comb begin
        enq_cnt = '0;
        for (int p = 0; p < ENQ_PORTS; p++) begin
            enq_cnt = enq_cnt + CNT_W'(i_enq_vld[p]);
            for (int s = 0; s < NUM_SRCS; s++) begin
                enq_rdy_w[p][s] = i_enq_rdy[p][s] | wb_hit(i_enq_uop[p].src_tag[s]);
            end
        end
    end

    // scan downward so the lowest ready index wins
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int e = DEPTH - 1; e >= 0; e--) begin
            if (ent_vld[e] && (&ent_rdy[e])) begin
                sel_found = 1'b1;
                sel_idx   = IDX_W'(e);
            end
        end
    end

    assign iss_fire  = sel_found && !i_stall;
    assign o_iss_vld = iss_fire;
    assign o_iss_uop = ent_uop[sel_idx];

    assign free_nxt  = free_cnt + CNT_W'(iss_fire) - enq_cnt;
    assign o_can_enq = (free_cnt >= CNT_W'(ENQ_PORTS));

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ent_vld  <= '0;
            free_cnt <= CNT_W'(DEPTH);
        end else if (i_squash) begin
            ent_vld  <= '0;
            free_cnt <= CNT_W'(DEPTH);
        end else begin
            // issued entry and enqueue targets never overlap
            if (iss_fire) begin
                ent_vld[sel_idx] <= 1'b0;
            end
            for (int p = 0; p < ENQ_PORTS; p++) begin
                if (i_enq_vld[p]) begin
                    ent_vld[free_idx[p]] <= 1'b1;
                end
            end
            free_cnt <= free_nxt;
        end
    end

    always_ff @(posedge clk) begin
        // wakeup of waiting sources
        for (int e = 0; e < DEPTH; e++) begin
            for (int s = 0; s < NUM_SRCS; s++) begin
                if (wb_hit(ent_uop[e].src_tag[s])) begin
                    ent_rdy[e][s] <= 1'b1;
                end
            end
        end
        for (int p = 0; p < ENQ_PORTS; p++) begin
            if (i_enq_vld[p]) begin
                ent_uop[free_idx[p]] <= i_enq_uop[p];
                ent_rdy[free_idx[p]] <= enq_rdy_w[p];
            end
        end
    end

endmodule

`default_nettype wire

/* mem_dispatch_steer.sv */
// Steers dispatch slots to the load and store queues as an in-order prefix.
// At most ENQ_PORTS slots go to one queue per cycle; the ack is combinational.
`timescale 1ns/1ps
`default_nettype none

module mem_dispatch_steer
    import mem_pkg::*;
#(
    parameter int DISP_WIDTH = 4
) (
    input  wire logic [DISP_WIDTH-1:0] i_disp_req,
    input  mem_uop_t                   i_disp_uop [DISP_WIDTH],
    input  src_rdy_t                   i_disp_rdy [DISP_WIDTH],
    input  wire logic                  i_lq_can_enq,
    input  wire logic                  i_sq_can_enq,

    output logic [DISP_WIDTH-1:0]      o_disp_ack,

    output logic [ENQ_PORTS-1:0]       o_lq_enq_vld,
    output mem_uop_t                   o_lq_enq_uop [ENQ_PORTS],
    output src_rdy_t                   o_lq_enq_rdy [ENQ_PORTS],
    output logic [ENQ_PORTS-1:0]       o_sq_enq_vld,
    output mem_uop_t                   o_sq_enq_uop [ENQ_PORTS],
    output src_rdy_t                   o_sq_enq_rdy [ENQ_PORTS]
);

    logic [DISP_WIDTH-1:0] sel_ld;
    logic [DISP_WIDTH-1:0] sel_st;

    logic [DISP_WIDTH-1:0] ld_vld;
    mem_uop_t              ld_uop [DISP_WIDTH];
    src_rdy_t              ld_rdy [DISP_WIDTH];
    logic [DISP_WIDTH-1:0] st_vld;
    mem_uop_t              st_uop [DISP_WIDTH];
    src_rdy_t              st_rdy [DISP_WIDTH];

    // prefix chain with per-queue counts of earlier selections
    always_comb begin : accept_blk
        int  ld_cnt;
        int  st_cnt;
        logic prev_ok;
        ld_cnt  = 0;
        st_cnt  = 0;
        prev_ok = 1'b1;
        for (int i = 0; i < DISP_WIDTH; i++) begin
            sel_ld[i] = prev_ok && i_disp_req[i] && (i_disp_uop[i].kind == MEM_LOAD)
                        && i_lq_can_enq && (ld_cnt < ENQ_PORTS);
            sel_st[i] = prev_ok && i_disp_req[i] && (i_disp_uop[i].kind == MEM_STORE)
                        && i_sq_can_enq && (st_cnt < ENQ_PORTS);
            o_disp_ack[i] = sel_ld[i] || sel_st[i];
            // a refused or idle slot blocks every later slot
            prev_ok = o_disp_ack[i];
            ld_cnt  = ld_cnt + int'(sel_ld[i]);
            st_cnt  = st_cnt + int'(sel_st[i]);
        end
    end

    mem_compact #(.T(mem_uop_t), .N(DISP_WIDTH)) u_ld_uop_pack (
        .i_vld  (sel_ld),
        .i_data (i_disp_uop),
        .o_vld  (ld_vld),
        .o_data (ld_uop)
    );

    mem_compact #(.T(src_rdy_t), .N(DISP_WIDTH)) u_ld_rdy_pack (
        .i_vld  (sel_ld),
        .i_data (i_disp_rdy),
        .o_vld  (),
        .o_data (ld_rdy)
    );

    mem_compact #(.T(mem_uop_t), .N(DISP_WIDTH)) u_st_uop_pack (
        .i_vld  (sel_st),
        .i_data (i_disp_uop),
        .o_vld  (st_vld),
        .o_data (st_uop)
    );

    mem_compact #(.T(src_rdy_t), .N(DISP_WIDTH)) u_st_rdy_pack (
        .i_vld  (sel_st),
        .i_data (i_disp_rdy),
        .o_vld  (),
        .o_data (st_rdy)
    );

    // only the first ENQ_PORTS packed slots can be occupied
    always_comb begin
        for (int p = 0; p < ENQ_PORTS; p++) begin
            o_lq_enq_vld[p] = ld_vld[p];
            o_lq_enq_uop[p] = ld_uop[p];
            o_lq_enq_rdy[p] = ld_rdy[p];
            o_sq_enq_vld[p] = st_vld[p];
            o_sq_enq_uop[p] = st_uop[p];
            o_sq_enq_rdy[p] = st_rdy[p];
        end
    end

endmodule

`default_nettype wire

/* mem_compact.sv */
// Packs the selected entries toward index 0, keeping their relative order.
// Unused outputs carry zero with their valid low.
`timescale 1ns/1ps
`default_nettype none

module mem_compact #(
    parameter type T = logic,
    parameter int  N = 4
) (
    input  wire logic [N-1:0] i_vld,
    input  T                  i_data [N],
    output logic [N-1:0]      o_vld,
    output T                  o_data [N]
);

    always_comb begin : pack_blk
        int cnt;
        cnt   = 0;
        o_vld = '0;
        for (int k = 0; k < N; k++) begin
            o_data[k] = '0;
        end
        // cnt never runs ahead of i, so the write index stays in range
        for (int i = 0; i < N; i++) begin
            if (i_vld[i]) begin
                o_data[cnt] = i_data[i];
                o_vld[cnt]  = 1'b1;
                cnt         = cnt + 1;
            end
        end
    end

endmodule

`default_nettype wire

/* mem_pkg.sv */
// Shared widths and payload types for the memory dispatch and issue block.
// Each micro-op has exactly NUM_SRCS physical sources and ENQ_PORTS is the per-queue limit.
`default_nettype none

package mem_pkg;

    // physical register tag and ROB index widths
    localparam int PREG_W   = 6;
    localparam int ROB_W    = 6;
    localparam int IMM_W    = 12;

    // a load reads base and index or zero reg while a store reads base and data
    localparam int NUM_SRCS = 2;

    // entries written into one queue per cycle
    localparam int ENQ_PORTS = 2;

    typedef enum logic {
        MEM_LOAD  = 1'b0,
        MEM_STORE = 1'b1
    } mem_kind_e;

    typedef struct packed {
        mem_kind_e                          kind;
        logic [ROB_W-1:0]                   rob_idx;
        logic [NUM_SRCS-1:0][PREG_W-1:0]    src_tag;
        logic [PREG_W-1:0]                  dst_tag;
        logic [IMM_W-1:0]                   imm;
    } mem_uop_t;

    // one bit per source, set once the operand is available
    typedef logic [NUM_SRCS-1:0] src_rdy_t;

    // what an issue stage presents to execution
    typedef struct packed {
        mem_uop_t                           uop;
        logic [NUM_SRCS-1:0][PREG_W-1:0]    rf_idx;
    } mem_issue_t;

endpackage

`default_nettype wire
